//--- src/rot_map_pkg.sv
package rot_map_pkg;

	// bus geometry
	localparam int DATA_W = 32;

	// register map
	localparam logic [DATA_W-1:0] ADDR_CMD    = 32'h1000_0081; // command and unlock port
	localparam logic [DATA_W-1:0] ADDR_STATUS = 32'h1000_0000;
	localparam logic [DATA_W-1:0] ADDR_OPREG  = 32'h1000_0004; // last accepted opcode
	localparam logic [DATA_W-1:0] ADDR_KEY0   = 32'h1000_0010; // key words at +0..+3
	localparam logic [DATA_W-1:0] ADDR_PT0    = 32'h1000_0020; // plaintext words at +0..+3

	// number of words in the key and plaintext banks
	localparam int NUM_WORDS = 4;

	// compared bit by bit during unlock, msb first
	localparam logic [DATA_W-1:0] UNLOCK_PATTERN = 32'hF0F0_AAAA;

	// status word bit positions
	localparam int ST_UNLOCKED    = 0;
	localparam int ST_SEQ_BUSY    = 1; // unlock sequence in progress
	localparam int ST_KEY_LOADED  = 4;
	localparam int ST_UNLOCK_FAIL = 5; // sticky
	localparam int ST_BAD_OP      = 8; // sticky

endpackage

//--- src/rot_cmd_pkg.sv
package rot_cmd_pkg;

	typedef enum logic [rot_map_pkg::DATA_W-1:0] {
		OP_NOP          = 32'h0000_0000,
		OP_UNLOCK       = 32'h0000_0001,
		OP_STATUS_CLEAR = 32'h0000_0002,
		OP_KEY_CLEAR    = 32'h0000_0003,
		OP_LOCK         = 32'h0000_0004
	} rot_op_e;

	typedef enum logic [1:0] {LOCKED, SEQ, UNLOCKED} unlock_state_e;

	typedef enum logic [1:0] {RD_STATUS, RD_OPREG, RD_PT, RD_NONE} rd_sel_e;

	// raw bus request as driven by the host
	typedef struct packed {
		logic [rot_map_pkg::DATA_W-1:0] addr;
		logic [rot_map_pkg::DATA_W-1:0] data;
		logic                           we;
		logic                           re;
	} bus_req_t;

	// decoded access, one cycle behind the request
	typedef struct packed {
		logic                           cmd_wr;
		logic                           key_wr;
		logic                           pt_wr;
		logic [1:0]                     idx; // word within key or plaintext bank
		rd_sel_e                        rd_sel;
		logic                           other_wr; // any write not to the command port
		logic [rot_map_pkg::DATA_W-1:0] data;
	} access_t;

	localparam access_t ACC_IDLE = '{1'b0, 1'b0, 1'b0, 2'd0, RD_NONE, 1'b0, 32'd0};

endpackage

//--- src/bus_frontend.sv
`timescale 1ns/100ps

module bus_frontend (
	input  logic                 clk,
	input  logic                 rst_n,
	input  rot_cmd_pkg::bus_req_t req_i,
	output rot_cmd_pkg::access_t  acc_o
);

	rot_cmd_pkg::access_t acc_d;
	logic [rot_map_pkg::DATA_W-1:0] key_off; // offset into key range
	logic [rot_map_pkg::DATA_W-1:0] pt_off;
	logic key_hit;
	logic pt_hit;

	assign key_off = req_i.addr - rot_map_pkg::ADDR_KEY0;
	assign pt_off  = req_i.addr - rot_map_pkg::ADDR_PT0;
	assign key_hit = key_off < rot_map_pkg::NUM_WORDS;
	assign pt_hit  = pt_off < rot_map_pkg::NUM_WORDS;

	always_comb begin
		acc_d          = rot_cmd_pkg::ACC_IDLE;
		acc_d.cmd_wr   = req_i.we && (req_i.addr == rot_map_pkg::ADDR_CMD);
		acc_d.other_wr = req_i.we && (req_i.addr != rot_map_pkg::ADDR_CMD);
		acc_d.key_wr   = req_i.we && key_hit;
		acc_d.pt_wr    = req_i.we && pt_hit;
		acc_d.idx      = req_i.addr[1:0]; // both banks start on a four-word boundary
		acc_d.data     = req_i.data;
		if (req_i.re) begin
			if (req_i.addr == rot_map_pkg::ADDR_STATUS) acc_d.rd_sel = rot_cmd_pkg::RD_STATUS;
			else if (req_i.addr == rot_map_pkg::ADDR_OPREG) acc_d.rd_sel = rot_cmd_pkg::RD_OPREG;
			else if (pt_hit) acc_d.rd_sel = rot_cmd_pkg::RD_PT;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) acc_o <= rot_cmd_pkg::ACC_IDLE;
		else acc_o <= acc_d;
	end

	// map ranges must not overlap
	a_wr_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0({acc_o.cmd_wr, acc_o.key_wr, acc_o.pt_wr}));

endmodule

//--- src/unlock_seq.sv
`timescale 1ns/100ps

module unlock_seq (
	input  logic                clk,
	input  logic                rst_n,
	input  rot_cmd_pkg::access_t acc_i,
	input  logic                lock_i,
	input  logic                flags_clr_i,
	output logic                unlocked_o,
	output logic                seq_busy_o,
	output logic                unlock_fail_o
);

	rot_cmd_pkg::unlock_state_e state_q;
	logic [4:0] step_q; // write number within the sequence
	logic [4:0] bit_idx;
	logic       match_q; // all bits so far matched
	logic       bit_ok;

	assign bit_idx = 5'd31 - step_q; // msb first
	assign bit_ok  = acc_i.data[bit_idx] == rot_map_pkg::UNLOCK_PATTERN[bit_idx];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q       <= rot_cmd_pkg::LOCKED;
			step_q        <= '0;
			match_q       <= 1'b0;
			unlock_fail_o <= 1'b0;
		end else begin
			if (flags_clr_i) unlock_fail_o <= 1'b0;
			unique case (state_q)
				rot_cmd_pkg::LOCKED: begin
					if (acc_i.cmd_wr && acc_i.data == rot_cmd_pkg::OP_UNLOCK) begin
						state_q <= rot_cmd_pkg::SEQ;
						match_q <= 1'b1;
					end
				end
				rot_cmd_pkg::SEQ: begin
					if (acc_i.other_wr) begin // stray write aborts
						state_q       <= rot_cmd_pkg::LOCKED;
						step_q        <= '0;
						unlock_fail_o <= 1'b1;
					end else if (acc_i.cmd_wr) begin
						if (step_q == 5'd31) begin
							step_q <= '0;
							if (match_q && bit_ok) begin
								state_q <= rot_cmd_pkg::UNLOCKED;
							end else begin
								state_q       <= rot_cmd_pkg::LOCKED;
								unlock_fail_o <= 1'b1;
							end
						end else begin
							step_q  <= step_q + 5'd1;
							match_q <= match_q & bit_ok;
						end
					end
				end
				rot_cmd_pkg::UNLOCKED: begin
					if (lock_i) state_q <= rot_cmd_pkg::LOCKED;
				end
				default: state_q <= rot_cmd_pkg::LOCKED;
			endcase
		end
	end

	assign unlocked_o = state_q == rot_cmd_pkg::UNLOCKED;
	assign seq_busy_o = state_q == rot_cmd_pkg::SEQ;

	a_step_idle: assert property (@(posedge clk) disable iff (!rst_n)
		(state_q != rot_cmd_pkg::SEQ) |-> (step_q == 5'd0));
	a_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(unlocked_o && seq_busy_o));

endmodule

//--- src/cmd_ctrl.sv
`timescale 1ns/100ps

module cmd_ctrl (
	input  logic                clk,
	input  logic                rst_n,
	input  rot_cmd_pkg::access_t acc_i,
	input  logic                unlocked_i,
	output logic                lock_o,
	output logic                flags_clr_o,
	output logic                key_clr_o,
	output rot_cmd_pkg::rot_op_e opreg_o,
	output logic                bad_op_o
);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lock_o      <= 1'b0;
			flags_clr_o <= 1'b0;
			key_clr_o   <= 1'b0;
			opreg_o     <= rot_cmd_pkg::OP_NOP;
			bad_op_o    <= 1'b0;
		end else begin
			lock_o      <= 1'b0; // pulses last one cycle
			flags_clr_o <= 1'b0;
			key_clr_o   <= 1'b0;
			if (flags_clr_o) bad_op_o <= 1'b0;
			// while locked the command port belongs to unlock_seq
			if (acc_i.cmd_wr && unlocked_i) begin
				case (acc_i.data)
					rot_cmd_pkg::OP_NOP: opreg_o <= rot_cmd_pkg::OP_NOP;
					rot_cmd_pkg::OP_STATUS_CLEAR: begin
						flags_clr_o <= 1'b1;
						opreg_o     <= rot_cmd_pkg::OP_STATUS_CLEAR;
					end
					rot_cmd_pkg::OP_KEY_CLEAR: begin
						key_clr_o <= 1'b1;
						opreg_o   <= rot_cmd_pkg::OP_KEY_CLEAR;
					end
					rot_cmd_pkg::OP_LOCK: begin
						lock_o  <= 1'b1;
						opreg_o <= rot_cmd_pkg::OP_LOCK;
					end
					default: bad_op_o <= 1'b1; // unknown, or unlock while unlocked
				endcase
			end
		end
	end

	a_pulse_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0({lock_o, flags_clr_o, key_clr_o}));

endmodule

//--- src/key_store.sv
`timescale 1ns/100ps

module key_store (
	input  logic                            clk,
	input  logic                            rst_n,
	input  rot_cmd_pkg::access_t            acc_i,
	input  logic                            unlocked_i,
	input  logic                            key_clr_i,
	output logic [rot_map_pkg::DATA_W-1:0] pt_rd_o,
	output logic                            key_loaded_o
);

	logic [rot_map_pkg::NUM_WORDS-1:0][rot_map_pkg::DATA_W-1:0] key_q; // write-only
	logic [rot_map_pkg::NUM_WORDS-1:0][rot_map_pkg::DATA_W-1:0] pt_q;
	logic [rot_map_pkg::NUM_WORDS-1:0] key_mask_q; // key words written so far

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			key_q      <= '0;
			pt_q       <= '0;
			key_mask_q <= '0;
		end else if (key_clr_i) begin
			key_q      <= '0;
			pt_q       <= '0;
			key_mask_q <= '0;
		end else if (unlocked_i) begin
			if (acc_i.key_wr) begin
				key_q[acc_i.idx]      <= acc_i.data;
				key_mask_q[acc_i.idx] <= 1'b1;
			end
			if (acc_i.pt_wr) pt_q[acc_i.idx] <= acc_i.data;
		end
	end

	assign key_loaded_o = &key_mask_q;
	assign pt_rd_o      = pt_q[acc_i.idx]; // read select rides on the same index

endmodule

//--- src/read_port.sv
`timescale 1ns/100ps

module read_port (
	input  logic                            clk,
	input  logic                            rst_n,
	input  rot_cmd_pkg::access_t            acc_i,
	input  logic                            unlocked_i,
	input  logic                            seq_busy_i,
	input  logic                            unlock_fail_i,
	input  logic                            key_loaded_i,
	input  logic                            bad_op_i,
	input  rot_cmd_pkg::rot_op_e            opreg_i,
	input  logic [rot_map_pkg::DATA_W-1:0] pt_rd_i,
	output logic [rot_map_pkg::DATA_W-1:0] data_o
);

	logic [rot_map_pkg::DATA_W-1:0] status;
	logic [rot_map_pkg::DATA_W-1:0] rd_data;

	always_comb begin
		status                              = '0; // unused bits read zero
		status[rot_map_pkg::ST_UNLOCKED]    = unlocked_i;
		status[rot_map_pkg::ST_SEQ_BUSY]    = seq_busy_i;
		status[rot_map_pkg::ST_KEY_LOADED]  = key_loaded_i;
		status[rot_map_pkg::ST_UNLOCK_FAIL] = unlock_fail_i;
		status[rot_map_pkg::ST_BAD_OP]      = bad_op_i;
	end

	always_comb begin
		unique case (acc_i.rd_sel)
			rot_cmd_pkg::RD_STATUS: rd_data = status;
			rot_cmd_pkg::RD_OPREG:  rd_data = opreg_i;
			rot_cmd_pkg::RD_PT:     rd_data = pt_rd_i;
			default:                rd_data = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) data_o <= '0;
		else if (acc_i.rd_sel != rot_cmd_pkg::RD_NONE) data_o <= rd_data; // hold between reads
	end

endmodule

//--- src/rot_top.sv
`timescale 1ns/100ps

module rot_top (
	input  logic                            clk,
	input  logic                            rst_n,
	input  rot_cmd_pkg::bus_req_t           req_i,
	output logic [rot_map_pkg::DATA_W-1:0] data_o
);

	rot_cmd_pkg::access_t           acc;
	rot_cmd_pkg::rot_op_e           opreg;
	logic                           unlocked;
	logic                           seq_busy;
	logic                           unlock_fail;
	logic                           lock_p;
	logic                           flags_clr_p;
	logic                           key_clr_p;
	logic                           bad_op;
	logic                           key_loaded;
	logic [rot_map_pkg::DATA_W-1:0] pt_rd;

	bus_frontend i_bus_frontend (.clk(clk), .rst_n(rst_n), .req_i(req_i), .acc_o(acc));

	unlock_seq i_unlock_seq (
		.clk(clk), .rst_n(rst_n), .acc_i(acc),
		.lock_i(lock_p), .flags_clr_i(flags_clr_p),
		.unlocked_o(unlocked), .seq_busy_o(seq_busy), .unlock_fail_o(unlock_fail)
	);

	cmd_ctrl i_cmd_ctrl (
		.clk(clk), .rst_n(rst_n), .acc_i(acc), .unlocked_i(unlocked),
		.lock_o(lock_p), .flags_clr_o(flags_clr_p), .key_clr_o(key_clr_p),
		.opreg_o(opreg), .bad_op_o(bad_op)
	);

	key_store i_key_store (
		.clk(clk), .rst_n(rst_n), .acc_i(acc),
		.unlocked_i(unlocked), .key_clr_i(key_clr_p),
		.pt_rd_o(pt_rd), .key_loaded_o(key_loaded)
	);

	read_port i_read_port (
		.clk(clk), .rst_n(rst_n), .acc_i(acc),
		.unlocked_i(unlocked), .seq_busy_i(seq_busy), .unlock_fail_i(unlock_fail),
		.key_loaded_i(key_loaded), .bad_op_i(bad_op), .opreg_i(opreg),
		.pt_rd_i(pt_rd), .data_o(data_o)
	);

endmodule

//--- sim/tb_rot.sv
`timescale 1ns/100ps

module tb_rot;

	localparam int CLK_PERIOD = 100;
	localparam int RST_CYCLES = 4;
	localparam logic [31:0] SEED = 32'h1381_2a11;
	localparam int TEST_CYCLES [6] = '{20, 120, 80, 180, 80, 60}; // upper bound per test
	localparam int WD_MARGIN = 200;

	logic clk;
	logic rst_n;
	rot_cmd_pkg::bus_req_t req;
	logic [rot_map_pkg::DATA_W-1:0] data_o;

	logic [31:0] exp_data; // expected data_o of the read in flight
	int err_cnt;
	int chk_cnt;
	int test_cnt;
	int test_err_base;

	// expected register block state, tracked from the register rules
	logic m_unlocked;
	logic m_seq;
	logic m_fail;
	logic m_bad;
	logic [3:0] m_key_mask;
	logic [31:0] m_pt [4];
	logic [31:0] m_opreg;

	rot_top i_dut (.clk(clk), .rst_n(rst_n), .req_i(req), .data_o(data_o));

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin : watchdog
		int wd_cycles;
		wd_cycles = RST_CYCLES + WD_MARGIN;
		foreach (TEST_CYCLES[i]) wd_cycles += TEST_CYCLES[i];
		#(wd_cycles * CLK_PERIOD);
		$display("watchdog expired after %0d cycles, the tests did not finish", wd_cycles);
		$display("Done: errors found");
		$finish;
	end

	// read data lands two edges after re is sampled
	a_read_data: assert property (@(posedge clk) disable iff (!rst_n)
		$past(req.re, 2) |-> data_o == exp_data)
	else begin
		$display("ERROR at %0t: data_o expected %h, actual %h", $time, exp_data, data_o);
		err_cnt++;
	end

	function automatic logic [31:0] exp_status();
		logic [31:0] s;
		s = '0;
		s[rot_map_pkg::ST_UNLOCKED]    = m_unlocked;
		s[rot_map_pkg::ST_SEQ_BUSY]    = m_seq;
		s[rot_map_pkg::ST_KEY_LOADED]  = &m_key_mask;
		s[rot_map_pkg::ST_UNLOCK_FAIL] = m_fail;
		s[rot_map_pkg::ST_BAD_OP]      = m_bad;
		return s;
	endfunction

	// all bus tasks start and end on a falling edge
	task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
		req.addr = addr;
		req.data = data;
		req.we   = 1'b1;
		@(negedge clk);
		req.we = 1'b0; // a following write overrides this in the same step
	endtask

	task automatic bus_read(input logic [31:0] addr, input logic [31:0] exp);
		req.addr = addr;
		req.re   = 1'b1;
		exp_data = exp; // held until the check has fired
		chk_cnt++;
		@(negedge clk);
		req.re = 1'b0;
		repeat (2) @(negedge clk);
	endtask

	task automatic settle();
		repeat (3) @(negedge clk);
	endtask

	// OP_UNLOCK then steps pattern writes; bad_step < 0 keeps every bit right
	task automatic send_unlock(input int steps, input int bad_step);
		logic [31:0] word;
		bus_write(rot_map_pkg::ADDR_CMD, rot_cmd_pkg::OP_UNLOCK);
		for (int k = 0; k < steps; k++) begin
			word = $urandom;
			word[31-k] = rot_map_pkg::UNLOCK_PATTERN[31-k] ^ (k == bad_step);
			bus_write(rot_map_pkg::ADDR_CMD, word);
		end
		m_seq = steps < 32;
		if (steps == 32 && bad_step < 0) m_unlocked = 1'b1;
		else if (steps == 32) m_fail = 1'b1;
	endtask

	task automatic issue_cmd(input logic [31:0] op);
		bus_write(rot_map_pkg::ADDR_CMD, op);
		if (m_unlocked) begin
			case (op)
				rot_cmd_pkg::OP_NOP: m_opreg = op;
				rot_cmd_pkg::OP_STATUS_CLEAR: begin
					m_fail  = 1'b0;
					m_bad   = 1'b0;
					m_opreg = op;
				end
				rot_cmd_pkg::OP_KEY_CLEAR: begin
					m_key_mask = '0;
					foreach (m_pt[i]) m_pt[i] = '0;
					m_opreg = op;
				end
				rot_cmd_pkg::OP_LOCK: begin
					m_unlocked = 1'b0;
					m_opreg    = op;
				end
				default: m_bad = 1'b1; // includes OP_UNLOCK while unlocked
			endcase
		end
		settle();
	endtask

	task automatic write_word(input logic is_key, input int idx, input logic [31:0] data);
		if (is_key) bus_write(rot_map_pkg::ADDR_KEY0 + 32'(idx), data);
		else bus_write(rot_map_pkg::ADDR_PT0 + 32'(idx), data);
		if (m_seq) begin // stray write aborts the sequence
			m_seq  = 1'b0;
			m_fail = 1'b1;
		end else if (m_unlocked && is_key) m_key_mask[idx] = 1'b1;
		else if (m_unlocked) m_pt[idx] = data;
	endtask

	task automatic check_status();
		bus_read(rot_map_pkg::ADDR_STATUS, exp_status());
	endtask

	task automatic check_opreg();
		bus_read(rot_map_pkg::ADDR_OPREG, m_opreg);
	endtask

	task automatic check_all_pt();
		for (int i = 0; i < 4; i++) bus_read(rot_map_pkg::ADDR_PT0 + 32'(i), m_pt[i]);
	endtask

	task automatic end_test(input string name);
		int errs;
		errs = err_cnt - test_err_base;
		test_cnt++;
		$display("test %0d %s: %0d errors, %s", test_cnt, name, errs, errs == 0 ? "ok" : "FAILED");
		test_err_base = err_cnt;
	endtask

	initial begin : main
		logic [31:0] word;
		req = '0;
		rst_n = 1'b0;
		exp_data = '0;
		err_cnt = 0;
		chk_cnt = 0;
		test_cnt = 0;
		test_err_base = 0;
		{m_unlocked, m_seq, m_fail, m_bad, m_key_mask} = '0;
		foreach (m_pt[i]) m_pt[i] = '0;
		m_opreg = rot_cmd_pkg::OP_NOP;
		void'($urandom(SEED));
		repeat (RST_CYCLES) @(negedge clk);
		rst_n = 1'b1;

		check_status();
		check_opreg();
		end_test("reset values");

		send_unlock(32, -1);
		settle();
		check_status();
		issue_cmd(rot_cmd_pkg::OP_LOCK);
		send_unlock(32, int'($urandom_range(31, 0))); // one wrong bit
		settle();
		check_status();
		end_test("unlock pattern");

		// start from a clear fail flag so the abort has to set it
		send_unlock(32, -1);
		settle();
		issue_cmd(rot_cmd_pkg::OP_STATUS_CLEAR);
		issue_cmd(rot_cmd_pkg::OP_LOCK);
		send_unlock(10, -1);
		check_status(); // still busy
		write_word(1'b0, 0, $urandom);
		settle();
		check_status();
		end_test("abort by stray write");

		send_unlock(32, -1);
		settle();
		for (int i = 0; i < 4; i++) write_word(1'b0, i, $urandom);
		check_all_pt();
		for (int i = 0; i < 4; i++) write_word(1'b1, i, $urandom);
		settle();
		check_status();
		issue_cmd(rot_cmd_pkg::OP_KEY_CLEAR);
		check_all_pt();
		check_status();
		check_opreg();
		issue_cmd(rot_cmd_pkg::OP_LOCK);
		for (int i = 0; i < 4; i++) write_word(1'b0, i, $urandom);
		for (int i = 0; i < 4; i++) write_word(1'b1, i, $urandom);
		settle();
		check_all_pt();
		check_status();
		end_test("key and plaintext");

		send_unlock(32, -1);
		settle();
		word = 32'h0000_0100 + ($urandom & 32'h0000_ffff); // outside the opcode set
		issue_cmd(word);
		check_status();
		check_opreg();
		issue_cmd(rot_cmd_pkg::OP_STATUS_CLEAR);
		check_status();
		check_opreg();
		end_test("bad opcode and status clear");

		issue_cmd(rot_cmd_pkg::OP_LOCK);
		check_status();
		check_opreg();
		for (int i = 0; i < 4; i++) write_word(1'b1, i, $urandom);
		settle();
		check_status();
		end_test("relock");

		$display("tests %0d, checks %0d, errors %0d", test_cnt, chk_cnt, err_cnt);
		if (err_cnt == 0) $display("Done: no errors");
		else $display("Done: errors found");
		$finish;
	end

endmodule

//--- build.f
src/rot_map_pkg.sv
src/rot_cmd_pkg.sv
src/bus_frontend.sv
src/unlock_seq.sv
src/cmd_ctrl.sv
src/key_store.sv
src/read_port.sv
src/rot_top.sv
sim/tb_rot.sv

//--- Makefile
TOP := tb_rot

all: run

obj_dir/V$(TOP): build.f $(wildcard src/*.sv sim/*.sv)
	verilator --binary --timing --assert -f build.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	! grep -q "Done: errors found" sim.log
	grep -q "Done: no errors" sim.log

lint:
	verilator --lint-only --timing -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean
